// ==== Bender.yml ====
package:
  name: lspc_vram

sources:
  - design/lspcVramPkg.sv
  - design/cpuVramRegs.sv
  - design/vramCmdFifo.sv
  - design/vramSlotWriter.sv
  - design/lspcVram.sv
  - target: test
    files:
      - sim/vramChecker.sv
      - sim/lspcVram_props.sv
      - sim/tbLspcVram.sv

// ==== all.f ====
design/lspcVramPkg.sv
design/cpuVramRegs.sv
design/vramCmdFifo.sv
design/vramSlotWriter.sv
design/lspcVram.sv
sim/vramChecker.sv
sim/lspcVram_props.sv
sim/tbLspcVram.sv

// ==== design/cpuVramRegs.sv ====
// ########################################
// CPU VRAM registers
// Address, step and data with write command issue
// ########################################

`timescale 1ns/100ps
`default_nettype none

module cpuVramRegs (
	input logic clk24m,
	input logic rst,
	input lspcVramPkg::regSelT cpuSel,
	input logic cpuWr,
	input lspcVramPkg::cpuDataT cpuWdata,
	output lspcVramPkg::cpuDataT cpuRdata,
	output logic cpuBusy,
	output lspcVramPkg::vramCmdT inCmd,
	output logic inReq,
	input logic inAck
);

	lspcVramPkg::vramAddrT addrReg;
	lspcVramPkg::vramAddrT stepReg;
	lspcVramPkg::vramAddrT addrInc;
	lspcVramPkg::vramDataT dataReg;
	lspcVramPkg::vramCmdT cmdReg;
	lspcVramPkg::hsStateT state;
	logic wrAddr;
	logic wrStep;
	logic wrData;

	// Write strobes per register
	assign wrAddr = cpuWr && (cpuSel == lspcVramPkg::REG_VRAMADDR);
	assign wrStep = cpuWr && (cpuSel == lspcVramPkg::REG_VRAMMOD);
	// Data write only starts a command from idle
	assign wrData = cpuWr && (cpuSel == lspcVramPkg::REG_VRAMRW)
		&& (state == lspcVramPkg::hsIdle);

	// Auto step, 16-bit wrapping add
	assign addrInc = addrReg + stepReg;

	// Address update type
	// Direct load on VRAMADDR, step after each VRAMRW
	always_ff @(posedge clk24m) begin
		if (rst) begin
			addrReg <= '0;
		end else if (wrAddr) begin
			addrReg <= cpuWdata;
		end else if (wrData) begin
			addrReg <= addrInc;
		end
	end

	// Step and last data word
	always_ff @(posedge clk24m) begin
		if (rst) begin
			stepReg <= '0;
			dataReg <= '0;
		end else begin
			if (wrStep) begin
				stepReg <= cpuWdata;
			end
			if (wrData) begin
				dataReg <= cpuWdata;
			end
		end
	end

	// Command uses address before the step
	always_ff @(posedge clk24m) begin
		if (wrData) begin
			cmdReg <= '{addr: addrReg, data: cpuWdata};
		end
	end

	// Sender handshake
	always_ff @(posedge clk24m) begin
		if (rst) begin
			state <= lspcVramPkg::hsIdle;
		end else begin
			case (state)
				lspcVramPkg::hsIdle: if (wrData) state <= lspcVramPkg::hsRequest;
				lspcVramPkg::hsRequest: if (inAck) state <= lspcVramPkg::hsRelease;
				// Wait for FIFO to drop ack
				lspcVramPkg::hsRelease: if (!inAck) state <= lspcVramPkg::hsIdle;
				default: state <= lspcVramPkg::hsIdle;
			endcase
		end
	end

	assign inCmd = cmdReg;
	assign inReq = (state == lspcVramPkg::hsRequest);
	// CPU held off for the whole handshake
	assign cpuBusy = (state != lspcVramPkg::hsIdle);

	// Readback mux
	always_comb begin
		case (cpuSel)
			lspcVramPkg::REG_VRAMADDR: cpuRdata = addrReg;
			lspcVramPkg::REG_VRAMRW: cpuRdata = dataReg;
			lspcVramPkg::REG_VRAMMOD: cpuRdata = stepReg;
			default: cpuRdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/lspcVram.sv ====
// ########################################
// LSPC CPU to VRAM write path
// ########################################

`timescale 1ns/100ps
`default_nettype none

module lspcVram #(
	parameter int FIFO_DEPTH = 4,
	parameter int SLOT_PERIOD = 8
) (
	input logic clk24m,
	input logic rst,
	input lspcVramPkg::regSelT cpuSel,
	input logic cpuWr,
	input lspcVramPkg::cpuDataT cpuWdata,
	output lspcVramPkg::cpuDataT cpuRdata,
	output logic cpuBusy,
	output lspcVramPkg::vramAddrT vramAddr,
	output lspcVramPkg::vramDataT vramData,
	output logic vramWe
);

	// Register block to FIFO
	lspcVramPkg::vramCmdT inCmd;
	logic inReq;
	logic inAck;
	// FIFO to slot writer
	lspcVramPkg::vramCmdT outCmd;
	logic outReq;
	logic outAck;

	cpuVramRegs regs (
		.clk24m(clk24m), .rst(rst), .cpuSel(cpuSel), .cpuWr(cpuWr),
		.cpuWdata(cpuWdata), .cpuRdata(cpuRdata), .cpuBusy(cpuBusy),
		.inCmd(inCmd), .inReq(inReq), .inAck(inAck)
	);

	vramCmdFifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmdFifo (
		.clk24m(clk24m), .rst(rst), .inCmd(inCmd), .inReq(inReq), .inAck(inAck),
		.outCmd(outCmd), .outReq(outReq), .outAck(outAck)
	);

	vramSlotWriter #(.SLOT_PERIOD(SLOT_PERIOD)) slotWriter (
		.clk24m(clk24m), .rst(rst), .outCmd(outCmd), .outReq(outReq), .outAck(outAck),
		.vramAddr(vramAddr), .vramData(vramData), .vramWe(vramWe)
	);

endmodule

`default_nettype wire

// ==== design/lspcVramPkg.sv ====
// ########################################
// LSPC VRAM path shared types
// Widths, write command and handshake states
// ########################################

`default_nettype none

package lspcVramPkg;

	// VRAM word address and data
	typedef logic [15:0] vramAddrT;
	typedef logic [15:0] vramDataT;

	// CPU side data word
	typedef logic [15:0] cpuDataT;

	// Register select from address bits 3 to 1
	typedef logic [2:0] regSelT;

	// Register map
	localparam regSelT REG_VRAMADDR = 3'd0;
	localparam regSelT REG_VRAMRW = 3'd1;
	localparam regSelT REG_VRAMMOD = 3'd2;

	// One pending VRAM write
	typedef struct packed {
		vramAddrT addr;
		vramDataT data;
	} vramCmdT;

	// Four-phase sender
	typedef enum logic [1:0] {hsIdle, hsRequest, hsRelease} hsStateT;

	// Slot writer holding register
	typedef enum logic [1:0] {wrEmpty, wrHolding, wrReleasing} writerStateT;

endpackage

`default_nettype wire

// ==== design/vramCmdFifo.sv ====
// ########################################
// VRAM command FIFO
// Four-phase receiver in, four-phase sender out
// ########################################

`timescale 1ns/100ps
`default_nettype none

module vramCmdFifo #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk24m,
	input logic rst,
	input lspcVramPkg::vramCmdT inCmd,
	input logic inReq,
	output logic inAck,
	output lspcVramPkg::vramCmdT outCmd,
	output logic outReq,
	input logic outAck
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

	lspcVramPkg::vramCmdT mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;
	lspcVramPkg::hsStateT outState;
	logic push;
	logic pop;

	// New request with room left
	assign push = inReq && !inAck && (count != FULL_COUNT);
	// Head leaves when consumer acks
	assign pop = (outState == lspcVramPkg::hsRequest) && outAck;

	// Input ack, withheld while full
	always_ff @(posedge clk24m) begin
		if (rst) begin
			inAck <= 1'b0;
		end else if (push) begin
			inAck <= 1'b1;
		end else if (!inReq) begin
			inAck <= 1'b0;
		end
	end

	// Storage
	always_ff @(posedge clk24m) begin
		if (push) begin
			mem[wrPtr] <= inCmd;
		end
	end

	// Pointers wrap on power of two depth
	always_ff @(posedge clk24m) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
		end
	end

	// Fill level
	always_ff @(posedge clk24m) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Output sender
	always_ff @(posedge clk24m) begin
		if (rst) begin
			outState <= lspcVramPkg::hsIdle;
		end else begin
			case (outState)
				lspcVramPkg::hsIdle: if (count != '0) outState <= lspcVramPkg::hsRequest;
				lspcVramPkg::hsRequest: if (outAck) outState <= lspcVramPkg::hsRelease;
				lspcVramPkg::hsRelease: if (!outAck) outState <= lspcVramPkg::hsIdle;
				default: outState <= lspcVramPkg::hsIdle;
			endcase
		end
	end

	// Head stays put until popped
	assign outCmd = mem[rdPtr];
	assign outReq = (outState == lspcVramPkg::hsRequest);

endmodule

`default_nettype wire

// ==== design/vramSlotWriter.sv ====
// ########################################
// VRAM slot writer
// Drives queued writes in CPU access slots
// ########################################

`timescale 1ns/100ps
`default_nettype none

module vramSlotWriter #(
	parameter int SLOT_PERIOD = 8
) (
	input logic clk24m,
	input logic rst,
	input lspcVramPkg::vramCmdT outCmd,
	input logic outReq,
	output logic outAck,
	output lspcVramPkg::vramAddrT vramAddr,
	output lspcVramPkg::vramDataT vramData,
	output logic vramWe
);

	localparam int CNT_W = $clog2(SLOT_PERIOD);
	localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(SLOT_PERIOD - 1);

	logic [CNT_W-1:0] slotCnt;
	lspcVramPkg::vramCmdT holdCmd;
	lspcVramPkg::writerStateT state;
	logic take;
	logic slotGo;

	// Accept only with holding register free
	assign take = (state == lspcVramPkg::wrEmpty) && outReq && !outAck;
	// Fire on the edge into slot zero
	assign slotGo = (state == lspcVramPkg::wrHolding) && (slotCnt == LAST_SLOT);

	// Free-running slot counter
	always_ff @(posedge clk24m) begin
		if (rst) begin
			slotCnt <= '0;
		end else if (slotCnt == LAST_SLOT) begin
			slotCnt <= '0;
		end else begin
			slotCnt <= slotCnt + 1'b1;
		end
	end

	// Ack side of the handshake
	always_ff @(posedge clk24m) begin
		if (rst) begin
			outAck <= 1'b0;
		end else if (take) begin
			outAck <= 1'b1;
		end else if (!outReq) begin
			outAck <= 1'b0;
		end
	end

	always_ff @(posedge clk24m) begin
		if (take) holdCmd <= outCmd;
	end

	// VRAM port, address and data hold between pulses
	always_ff @(posedge clk24m) begin
		if (slotGo) begin
			vramAddr <= holdCmd.addr;
			vramData <= holdCmd.data;
		end
	end

	// Single-cycle write strobe
	always_ff @(posedge clk24m) begin
		if (rst) vramWe <= 1'b0;
		else vramWe <= slotGo;
	end

	// Holding register state
	always_ff @(posedge clk24m) begin
		if (rst) begin
			state <= lspcVramPkg::wrEmpty;
		end else begin
			case (state)
				lspcVramPkg::wrEmpty: if (take) state <= lspcVramPkg::wrHolding;
				lspcVramPkg::wrHolding: if (slotGo) state <= lspcVramPkg::wrReleasing;
				// Free once ack is back low
				lspcVramPkg::wrReleasing: if (!outAck) state <= lspcVramPkg::wrEmpty;
				default: state <= lspcVramPkg::wrEmpty;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== sim/lspcVram_props.sv ====
// ########################################
// Handshake and write strobe assertions
// ########################################

`timescale 1ns/100ps
`default_nettype none

module lspcVramProps (
	input logic clk24m,
	input logic rst,
	input logic req,
	input logic ack,
	input logic we
);

	int failures = 0;

	// Sender keeps req up until ack
	reqHeld: assert property (@(posedge clk24m) disable iff (rst) req && !ack |=> req)
		else begin
			$error("req dropped before ack rose");
			failures++;
		end

	// Receiver keeps ack up until req falls
	ackHeld: assert property (@(posedge clk24m) disable iff (rst) ack && req |=> ack)
		else begin
			$error("ack dropped before req fell");
			failures++;
		end

	// Write and accept strobes last one cycle
	weSingle: assert property (@(posedge clk24m) disable iff (rst) we |=> !we)
		else begin
			$error("strobe high for two cycles in a row");
			failures++;
		end

endmodule

// Register block to FIFO link and the accept strobe
bind vramCmdFifo lspcVramProps fifoInProps (
	.clk24m(clk24m), .rst(rst), .req(inReq), .ack(inAck), .we(push)
);

// FIFO to writer link and the VRAM strobe
bind vramSlotWriter lspcVramProps writerProps (
	.clk24m(clk24m), .rst(rst), .req(outReq), .ack(outAck), .we(vramWe)
);

`default_nettype wire

// ==== sim/tbLspcVram.sv ====
// ########################################
// LSPC VRAM path testbench
// Random register writes, checked by vramChecker
// ########################################

`timescale 1ns/100ps
`default_nettype none

module tbLspcVram;

	localparam int SLOT_PERIOD = 8;
	localparam int BUSY_LIMIT = 200;
	localparam int DRAIN_LIMIT = 400;

	logic clk24m;
	logic rst;
	lspcVramPkg::regSelT cpuSel;
	logic cpuWr;
	lspcVramPkg::cpuDataT cpuWdata;
	lspcVramPkg::cpuDataT cpuRdata;
	logic cpuBusy;
	lspcVramPkg::vramAddrT vramAddr;
	lspcVramPkg::vramDataT vramData;
	logic vramWe;
	int chkErrors;
	int chkChecks;
	int chkWrites;
	int chkPending;
	logic [31:0] lfsrState;
	int timeouts;

	lspcVram dut (
		.clk24m(clk24m), .rst(rst), .cpuSel(cpuSel), .cpuWr(cpuWr), .cpuWdata(cpuWdata),
		.cpuRdata(cpuRdata), .cpuBusy(cpuBusy), .vramAddr(vramAddr), .vramData(vramData),
		.vramWe(vramWe)
	);

	vramChecker #(.SLOT_PERIOD(SLOT_PERIOD)) vramCheck (
		.clk24m(clk24m), .rst(rst), .cpuSel(cpuSel), .cpuWr(cpuWr), .cpuWdata(cpuWdata),
		.cpuRdata(cpuRdata), .cpuBusy(cpuBusy), .vramAddr(vramAddr), .vramData(vramData),
		.vramWe(vramWe), .errorCount(chkErrors), .checkCount(chkChecks),
		.writeCount(chkWrites), .pendingCount(chkPending)
	);

	initial begin
		clk24m = 1'b0;
		forever #20 clk24m = ~clk24m;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	// One step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic endRun();
		int propFails;
		propFails = dut.cmdFifo.fifoInProps.failures + dut.slotWriter.writerProps.failures;
		$display("Summary: %0d errors, %0d assert fails, %0d timeouts, %0d checks, %0d writes",
			chkErrors, propFails, timeouts, chkChecks, chkWrites);
		if (chkErrors == 0 && propFails == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	task automatic waitNotBusy();
		int n;
		n = 0;
		while (cpuBusy !== 1'b0 && n < BUSY_LIMIT) begin
			@(negedge clk24m);
			n++;
		end
		if (cpuBusy !== 1'b0) begin
			$display("Timeout at %0t: cpuBusy stayed high for %0d cycles", $time, n);
			timeouts++;
			endRun();
		end
	endtask

	// One-cycle write pulse followed by a random readback select
	task automatic cpuWrite(input lspcVramPkg::regSelT sel, input lspcVramPkg::cpuDataT data);
		waitNotBusy();
		cpuSel = sel;
		cpuWdata = data;
		cpuWr = 1'b1;
		@(negedge clk24m);
		cpuWr = 1'b0;
		cpuSel = 3'(randBits(3));
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			cpuSel = 3'(randBits(3));
			@(negedge clk24m);
		end
	endtask

	task automatic drainWrites();
		int n;
		n = 0;
		while (chkPending != 0 && n < DRAIN_LIMIT) begin
			cpuSel = 3'(randBits(3));
			@(negedge clk24m);
			n++;
		end
		if (chkPending != 0) begin
			$display("Timeout at %0t: %0d VRAM writes never reached the port", $time, chkPending);
			timeouts++;
			endRun();
		end
	endtask

	initial begin
		logic [2:0] pick;
		int runLen;
		lfsrState = 32'hbd31_cf4e;
		timeouts = 0;
		rst = 1'b1;
		cpuSel = '0;
		cpuWr = 1'b0;
		cpuWdata = '0;
		// Two reset edges, released on the falling edge
		repeat (2) @(posedge clk24m);
		@(negedge clk24m);
		rst = 1'b0;
		// Reset values on every select
		for (int s = 0; s < 8; s++) begin
			cpuSel = 3'(s);
			@(negedge clk24m);
		end
		idleCycles(16);
		// Run that wraps past the top of VRAM
		cpuWrite(lspcVramPkg::REG_VRAMADDR, 16'hfff0);
		cpuWrite(lspcVramPkg::REG_VRAMMOD, 16'h0007);
		repeat (6) cpuWrite(lspcVramPkg::REG_VRAMRW, 16'(randBits(16)));
		drainWrites();
		// Random base and step per run
		for (int r = 0; r < 3; r++) begin
			cpuWrite(lspcVramPkg::REG_VRAMADDR, 16'(randBits(16)));
			cpuWrite(lspcVramPkg::REG_VRAMMOD, 16'(randBits(16)));
			runLen = 3 + randBits(3);
			repeat (runLen) cpuWrite(lspcVramPkg::REG_VRAMRW, 16'(randBits(16)));
			idleCycles(randBits(4));
		end
		drainWrites();
		// Back-to-back mix to fill the FIFO
		for (int i = 0; i < 64; i++) begin
			pick = 3'(randBits(3));
			if (pick < 3'd5) cpuWrite(lspcVramPkg::REG_VRAMRW, 16'(randBits(16)));
			else if (pick == 3'd5) cpuWrite(lspcVramPkg::REG_VRAMADDR, 16'(randBits(16)));
			else if (pick == 3'd6) cpuWrite(lspcVramPkg::REG_VRAMMOD, 16'(randBits(16)));
			else cpuWrite(3'(3 + randBits(2)), 16'(randBits(16)));
		end
		drainWrites();
		idleCycles(SLOT_PERIOD * 2);
		endRun();
	end

endmodule

`default_nettype wire

// ==== sim/vramChecker.sv ====
// ########################################
// VRAM path checker
// Register model and expected write queue
// ########################################

`timescale 1ns/100ps
`default_nettype none

module vramChecker #(
	parameter int SLOT_PERIOD = 8
) (
	input logic clk24m,
	input logic rst,
	input lspcVramPkg::regSelT cpuSel,
	input logic cpuWr,
	input lspcVramPkg::cpuDataT cpuWdata,
	input lspcVramPkg::cpuDataT cpuRdata,
	input logic cpuBusy,
	input lspcVramPkg::vramAddrT vramAddr,
	input lspcVramPkg::vramDataT vramData,
	input logic vramWe,
	output int errorCount,
	output int checkCount,
	output int writeCount,
	output int pendingCount
);

	lspcVramPkg::vramAddrT addrModel;
	lspcVramPkg::vramAddrT stepModel;
	lspcVramPkg::vramDataT dataModel;
	lspcVramPkg::vramCmdT expQ[$];
	lspcVramPkg::vramCmdT expCmd;
	lspcVramPkg::cpuDataT expRdata;
	int errors = 0;
	int checks = 0;
	int writes = 0;
	int cycle = 0;
	int lastWe = -1;
	bit sawData = 1'b0;
	bit busyDue = 1'b0;

	assign errorCount = errors;
	assign checkCount = checks;
	assign writeCount = writes;
	assign pendingCount = expQ.size();

	task automatic valueError(input string name, input logic [15:0] expv, input logic [15:0] actv);
		$display("FAILED t=%0t %s expected %h actual %h", $time, name, expv, actv);
		errors++;
	endtask

	task automatic plainError(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	always @(posedge clk24m) begin
		if (rst) begin
			addrModel = '0;
			stepModel = '0;
			dataModel = '0;
			expQ.delete();
			sawData = 1'b0;
			busyDue = 1'b0;
			lastWe = -1;
			cycle = 0;
		end else begin
			cycle++;
			// Readback where unused selects read zero
			case (cpuSel)
				lspcVramPkg::REG_VRAMADDR: expRdata = addrModel;
				lspcVramPkg::REG_VRAMMOD: expRdata = stepModel;
				lspcVramPkg::REG_VRAMRW: expRdata = dataModel;
				default: expRdata = '0;
			endcase
			checks++;
			if (cpuRdata !== expRdata) valueError("cpuRdata", expRdata, cpuRdata);
			if (cpuBusy !== 1'b0 && !sawData) plainError("cpuBusy high before any VRAMRW write");
			// cpuBusy rises in the cycle after a data write
			if (busyDue && cpuBusy !== 1'b1) valueError("cpuBusy", 16'd1, {15'd0, cpuBusy});
			busyDue = 1'b0;
			// VRAM port
			if (vramWe === 1'b1) begin
				if (expQ.size() == 0) begin
					plainError("vramWe pulse with no write pending");
				end else begin
					expCmd = expQ.pop_front();
					if (vramAddr !== expCmd.addr) valueError("vramAddr", expCmd.addr, vramAddr);
					if (vramData !== expCmd.data) valueError("vramData", expCmd.data, vramData);
					writes++;
				end
				// Writes only land in slot zero
				if (lastWe >= 0 && ((cycle - lastWe) % SLOT_PERIOD) != 0)
					plainError($sformatf("vramWe gap of %0d cycles is off the slot grid",
						cycle - lastWe));
				lastWe = cycle;
			end else if (vramWe !== 1'b0) begin
				plainError("vramWe is unknown");
			end
			// Model update after the readback compare
			if (cpuWr === 1'b1) begin
				case (cpuSel)
					lspcVramPkg::REG_VRAMADDR: addrModel = cpuWdata;
					lspcVramPkg::REG_VRAMMOD: stepModel = cpuWdata;
					lspcVramPkg::REG_VRAMRW: begin
						expQ.push_back('{addr: addrModel, data: cpuWdata});
						dataModel = cpuWdata;
						// Step wraps at 16 bits
						addrModel = addrModel + stepModel;
						sawData = 1'b1;
						busyDue = 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire
